/* design/icmp_settings.svh */
// ----------------------------
// constants for the ICMP echo responder
// include in any file that needs a width or an ICMP field value
// ----------------------------
`ifndef ICMP_SETTINGS_SVH
`define ICMP_SETTINGS_SVH

`define ICMP_DATA_W        8        // one message byte
`define ICMP_LEN_W         16       // lengths and byte counters
`define ICMP_RAM_DEPTH     256      // payload bytes held
`define ICMP_RAM_AW        8
`define ICMP_HDR_BYTES     8        // type, code, checksum, id, seq

// ICMP type field values
`define ICMP_ECHO_REQUEST  8'd8
`define ICMP_ECHO_REPLY    8'd0

`define ICMP_TIMEOUT       65535    // cycles allowed for tx_data_req

`endif

/* design/icmp_pkg.sv */
// ----------------------------
// shared types for the ICMP echo responder
// refer to them as icmp_pkg::name
// ----------------------------
`include "icmp_settings.svh"

package icmp_pkg;

  typedef logic [`ICMP_DATA_W-1:0] byte_t;
  typedef logic [`ICMP_LEN_W-1:0]  len_t;      // length or byte index
  typedef logic [15:0]             word_t;     // id, seq, checksum
  typedef logic [`ICMP_RAM_AW-1:0] ram_addr_t;

  // receive side
  typedef enum logic [2:0] {
    RX_IDLE,
    RX_RECV,
    RX_ODD,      // last byte of an odd length message
    RX_VERIFY,
    RX_ERROR
  } rx_state_t;

  // transmit handshake
  typedef enum logic [2:0] {
    TX_IDLE,
    TX_WAIT_ACK,
    TX_WAIT_REQ,
    TX_SEND,
    TX_WAIT_DONE
  } tx_state_t;

endpackage

/* design/icmp_payload_ram.sv */
// ----------------------------
// payload store between the receive and transmit sides
// one write port, one read port with registered output
// ----------------------------
`timescale 1ns/10ps
`include "icmp_settings.svh"

module icmp_payload_ram
(
  input  logic                clk,
  input  logic                wr_en,
  input  icmp_pkg::ram_addr_t wr_addr,
  input  icmp_pkg::byte_t     wr_data,
  input  icmp_pkg::ram_addr_t rd_addr,
  output icmp_pkg::byte_t     rd_data
);

  icmp_pkg::byte_t mem [`ICMP_RAM_DEPTH];

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

  // data one cycle after the address
  always_ff @(posedge clk)
  begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* design/icmp_rx_parser.sv */
// ----------------------------
// ICMP receive side: checks an echo request byte stream,
// stores the payload and hands the reply fields to the framer
// ----------------------------
`timescale 1ns/10ps
`include "icmp_settings.svh"

module icmp_rx_parser
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rx_start,
  input  icmp_pkg::len_t      rx_len,
  input  icmp_pkg::byte_t     rx_data,
  input  logic                rx_error,
  input  logic                busy,
  output logic                wr_en,
  output icmp_pkg::ram_addr_t wr_addr,
  output icmp_pkg::byte_t     wr_data,
  output logic                reply_start,
  output icmp_pkg::len_t      reply_len,
  output icmp_pkg::byte_t     reply_code,
  output icmp_pkg::word_t     reply_id,
  output icmp_pkg::word_t     reply_seq,
  output icmp_pkg::word_t     reply_checksum
);

  localparam icmp_pkg::len_t HDR_LEN = icmp_pkg::len_t'(`ICMP_HDR_BYTES);
  localparam icmp_pkg::len_t MAX_LEN = icmp_pkg::len_t'(`ICMP_HDR_BYTES + `ICMP_RAM_DEPTH);

  icmp_pkg::rx_state_t state, state_nxt;
  icmp_pkg::len_t      cnt;         // index of the byte on rx_data
  icmp_pkg::byte_t     hi_byte;     // first byte of the current word
  logic [31:0]         vsum, rsum;  // verify and reply sums
  logic [31:0]         vfold, rfold;
  logic [1:0]          vcnt;
  logic                sum_ok;
  logic                accept, len_bad, in_rx;

  assign accept  = rx_start && !busy && !reply_start;
  assign len_bad = (rx_len < HDR_LEN) || (rx_len > MAX_LEN);
  assign in_rx   = (state == icmp_pkg::RX_RECV) || (state == icmp_pkg::RX_ODD);

  always_comb
  begin
    state_nxt = state;
    case (state)
      icmp_pkg::RX_IDLE:
        if (accept)
          state_nxt = len_bad ? icmp_pkg::RX_ERROR : icmp_pkg::RX_RECV;
      icmp_pkg::RX_RECV:
        if (rx_error || (cnt == '0 && rx_data != `ICMP_ECHO_REQUEST))
          state_nxt = icmp_pkg::RX_ERROR;
        else if (!reply_len[0] && cnt == reply_len - 16'd1)
          state_nxt = icmp_pkg::RX_VERIFY;
        else if (reply_len[0] && cnt == reply_len - 16'd2)
          state_nxt = icmp_pkg::RX_ODD;   // one byte left over
      icmp_pkg::RX_ODD:
        state_nxt = rx_error ? icmp_pkg::RX_ERROR : icmp_pkg::RX_VERIFY;
      icmp_pkg::RX_VERIFY:
        if (vcnt == 2'd3)
          state_nxt = icmp_pkg::RX_IDLE;
      default:
        state_nxt = icmp_pkg::RX_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= icmp_pkg::RX_IDLE;
      cnt         <= '0;
      vcnt        <= '0;
      wr_en       <= 1'b0;
      reply_start <= 1'b0;
    end
    else
    begin
      state       <= state_nxt;
      cnt         <= in_rx ? cnt + 16'd1 : '0;
      vcnt        <= (state == icmp_pkg::RX_VERIFY) ? vcnt + 2'd1 : '0;
      wr_en       <= in_rx && (cnt >= HDR_LEN);   // payload bytes only
      reply_start <= (state == icmp_pkg::RX_VERIFY) && (vcnt == 2'd3) && sum_ok;
    end
  end

  always_ff @(posedge clk)
  begin
    wr_addr <= icmp_pkg::ram_addr_t'(cnt - HDR_LEN);
    wr_data <= rx_data;
    if (state == icmp_pkg::RX_IDLE && accept)
    begin
      reply_len <= rx_len;
      vsum      <= '0;
      rsum      <= '0;
    end
    if (state == icmp_pkg::RX_RECV)
    begin
      case (cnt)
        16'd1: reply_code      <= rx_data;
        16'd4: reply_id[15:8]  <= rx_data;
        16'd5: reply_id[7:0]   <= rx_data;
        16'd6: reply_seq[15:8] <= rx_data;
        16'd7: reply_seq[7:0]  <= rx_data;
        default: ;
      endcase
      if (!cnt[0])
        hi_byte <= rx_data;
      else
      begin
        vsum <= vsum + {16'd0, hi_byte, rx_data};
        // reply type replaces the request type, checksum word counts as zero
        if (cnt == 16'd1)
          rsum <= rsum + {16'd0, `ICMP_ECHO_REPLY, rx_data};
        else if (cnt != 16'd3)
          rsum <= rsum + {16'd0, hi_byte, rx_data};
      end
    end
    if (state == icmp_pkg::RX_ODD)
    begin
      vsum <= vsum + {16'd0, rx_data, 8'h00};   // zero pad
      rsum <= rsum + {16'd0, rx_data, 8'h00};
    end
    if (state == icmp_pkg::RX_VERIFY)
    begin
      case (vcnt)
        2'd0:
        begin
          vfold <= {16'd0, vsum[15:0]} + {16'd0, vsum[31:16]};
          rfold <= {16'd0, rsum[15:0]} + {16'd0, rsum[31:16]};
        end
        2'd1:
        begin
          vfold <= {16'd0, vfold[15:0]} + {16'd0, vfold[31:16]};
          rfold <= {16'd0, rfold[15:0]} + {16'd0, rfold[31:16]};
        end
        2'd2:
        begin
          sum_ok         <= (vfold[15:0] == 16'hffff);
          reply_checksum <= ~rfold[15:0];
        end
        default: ;
      endcase
    end
  end

  // payload writes stay inside the packet being received
  a_wr_in_pkt: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> (state != icmp_pkg::RX_IDLE)
              && (icmp_pkg::len_t'(wr_addr) + HDR_LEN < reply_len));

  a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    reply_start |=> !reply_start);

endmodule

/* design/icmp_tx_framer.sv */
// ----------------------------
// ICMP transmit side: IP layer handshake, then the echo reply
// bytes built from the parser fields and the payload RAM
// ----------------------------
`timescale 1ns/10ps
`include "icmp_settings.svh"

module icmp_tx_framer
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                reply_start,
  input  icmp_pkg::len_t      reply_len,
  input  icmp_pkg::byte_t     reply_code,
  input  icmp_pkg::word_t     reply_id,
  input  icmp_pkg::word_t     reply_seq,
  input  icmp_pkg::word_t     reply_checksum,
  input  logic                tx_ack,
  input  logic                tx_data_req,
  input  logic                mac_done,
  input  icmp_pkg::byte_t     rd_data,
  output logic                busy,
  output logic                tx_req,
  output logic                tx_ready,
  output logic                tx_valid,
  output icmp_pkg::byte_t     tx_data,
  output icmp_pkg::ram_addr_t rd_addr
);

  // address goes out two bytes ahead, RAM adds one more cycle
  localparam icmp_pkg::len_t RD_LEAD  = icmp_pkg::len_t'(`ICMP_HDR_BYTES - 2);
  localparam icmp_pkg::len_t TIME_MAX = icmp_pkg::len_t'(`ICMP_TIMEOUT - 1);

  icmp_pkg::tx_state_t state, state_nxt;
  icmp_pkg::len_t      idx;      // index of the byte loaded next
  icmp_pkg::len_t      timer;
  icmp_pkg::byte_t     tx_byte;

  assign busy = (state != icmp_pkg::TX_IDLE);

  always_comb
  begin
    state_nxt = state;
    case (state)
      icmp_pkg::TX_IDLE:
        if (reply_start)
          state_nxt = icmp_pkg::TX_WAIT_ACK;
      icmp_pkg::TX_WAIT_ACK:
        if (tx_ack)
          state_nxt = icmp_pkg::TX_WAIT_REQ;
      icmp_pkg::TX_WAIT_REQ:
        if (tx_data_req)
          state_nxt = icmp_pkg::TX_SEND;
        else if (timer == TIME_MAX)
          state_nxt = icmp_pkg::TX_IDLE;    // reply abandoned
      icmp_pkg::TX_SEND:
        if (idx == reply_len)
          state_nxt = icmp_pkg::TX_WAIT_DONE;
      icmp_pkg::TX_WAIT_DONE:
        if (mac_done)
          state_nxt = icmp_pkg::TX_IDLE;
      default:
        state_nxt = icmp_pkg::TX_IDLE;
    endcase
  end

  always_comb
  begin
    case (idx)
      16'd0:   tx_byte = `ICMP_ECHO_REPLY;
      16'd1:   tx_byte = reply_code;
      16'd2:   tx_byte = reply_checksum[15:8];
      16'd3:   tx_byte = reply_checksum[7:0];
      16'd4:   tx_byte = reply_id[15:8];
      16'd5:   tx_byte = reply_id[7:0];
      16'd6:   tx_byte = reply_seq[15:8];
      16'd7:   tx_byte = reply_seq[7:0];
      default: tx_byte = rd_data;   // payload
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= icmp_pkg::TX_IDLE;
      tx_req   <= 1'b0;
      tx_ready <= 1'b0;
      tx_valid <= 1'b0;
      tx_data  <= '0;
      idx      <= '0;
      timer    <= '0;
      rd_addr  <= '0;
    end
    else
    begin
      state    <= state_nxt;
      tx_req   <= (state_nxt == icmp_pkg::TX_WAIT_ACK);
      tx_ready <= (state_nxt == icmp_pkg::TX_WAIT_REQ);
      tx_valid <= (state_nxt == icmp_pkg::TX_SEND);
      tx_data  <= (state_nxt == icmp_pkg::TX_SEND) ? tx_byte : '0;
      idx      <= (state_nxt == icmp_pkg::TX_SEND) ? idx + 16'd1 : '0;
      timer    <= (state == icmp_pkg::TX_WAIT_REQ) ? timer + 16'd1 : '0;
      if (state == icmp_pkg::TX_SEND && idx >= RD_LEAD)
        rd_addr <= icmp_pkg::ram_addr_t'(idx - RD_LEAD);
      else
        rd_addr <= '0;
    end
  end

  // first reply byte only right after a data request while ready
  a_first_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(tx_valid) |-> $past(tx_data_req) && $past(tx_ready));

endmodule

/* design/icmp_reply.sv */
// ----------------------------
// ICMP echo responder top, between IP receive and transmit paths
// ----------------------------
`timescale 1ns/10ps

module icmp_reply
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            rx_start,
  input  icmp_pkg::len_t  rx_len,
  input  icmp_pkg::byte_t rx_data,
  input  logic            rx_error,
  input  logic            tx_ack,
  input  logic            tx_data_req,
  input  logic            mac_done,
  output logic            tx_req,
  output logic            tx_ready,
  output logic            tx_valid,
  output icmp_pkg::byte_t tx_data
);

  logic                wr_en;
  icmp_pkg::ram_addr_t wr_addr;
  icmp_pkg::byte_t     wr_data;
  icmp_pkg::ram_addr_t rd_addr;
  icmp_pkg::byte_t     rd_data;
  logic                busy;
  logic                reply_start;
  icmp_pkg::len_t      reply_len;
  icmp_pkg::byte_t     reply_code;
  icmp_pkg::word_t     reply_id;
  icmp_pkg::word_t     reply_seq;
  icmp_pkg::word_t     reply_checksum;

  icmp_rx_parser u_rx_parser
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .rx_start       (rx_start),
    .rx_len         (rx_len),
    .rx_data        (rx_data),
    .rx_error       (rx_error),
    .busy           (busy),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .reply_start    (reply_start),
    .reply_len      (reply_len),
    .reply_code     (reply_code),
    .reply_id       (reply_id),
    .reply_seq      (reply_seq),
    .reply_checksum (reply_checksum)
  );

  icmp_payload_ram u_payload_ram
  (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  icmp_tx_framer u_tx_framer
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .reply_start    (reply_start),
    .reply_len      (reply_len),
    .reply_code     (reply_code),
    .reply_id       (reply_id),
    .reply_seq      (reply_seq),
    .reply_checksum (reply_checksum),
    .tx_ack         (tx_ack),
    .tx_data_req    (tx_data_req),
    .mac_done       (mac_done),
    .rd_data        (rd_data),
    .busy           (busy),
    .tx_req         (tx_req),
    .tx_ready       (tx_ready),
    .tx_valid       (tx_valid),
    .tx_data        (tx_data),
    .rd_addr        (rd_addr)
  );

endmodule

/* verif/icmp_checker.sv */
// ----------------------------
// reply checker: captures each request on the receive inputs,
// builds the expected echo reply and compares tx_data with it
// ----------------------------
`timescale 1ns/10ps
`include "icmp_settings.svh"

module icmp_checker
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            rx_start,
  input  icmp_pkg::len_t  rx_len,
  input  icmp_pkg::byte_t rx_data,
  input  logic            tx_req,
  input  logic            tx_valid,
  input  icmp_pkg::byte_t tx_data,
  input  logic            pkt_done,
  input  logic            exp_reply,
  input  logic            req_allowed,   // tx_req may rise without a reply
  input  logic            report,
  output int              fail_count
);

  icmp_pkg::byte_t req [0:511];
  icmp_pkg::byte_t expect_b [0:511];
  int              req_len;
  int              rx_idx;
  int              rx_left;
  int              tx_idx;
  int              byte_errs;
  int              pkt_num;
  int              pass_count;
  logic            req_seen;

  // reply checksum over the reply words, checksum field as zero
  task automatic build_expected();
    logic [31:0]     sum;
    icmp_pkg::byte_t hi;
    icmp_pkg::byte_t lo;
    int              i;
    sum = '0;
    for (i = 0; i < req_len; i = i + 2)
    begin
      hi = (i == 0) ? `ICMP_ECHO_REPLY : req[i];
      lo = (i + 1 < req_len) ? req[i+1] : 8'h00;   // odd length pad
      if (i != 2)
        sum = sum + {16'h0, hi, lo};
    end
    while (sum[31:16] != 16'h0)
      sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
    for (i = 0; i < req_len && i < 512; i++)
      expect_b[i] = req[i];
    expect_b[0] = `ICMP_ECHO_REPLY;
    expect_b[2] = ~sum[15:8];
    expect_b[3] = ~sum[7:0];
  endtask

  task automatic close_packet();
    logic ok;
    ok = (byte_errs == 0);
    if (exp_reply && tx_idx != req_len)
    begin
      $display("packet %0d: reply had %0d bytes where %0d were expected",
               pkt_num, tx_idx, req_len);
      ok = 1'b0;
    end
    if (!exp_reply && tx_idx != 0)
    begin
      $display("packet %0d: reply bytes sent for a request that should be dropped", pkt_num);
      ok = 1'b0;
    end
    if (!exp_reply && !req_allowed && req_seen)
    begin
      $display("packet %0d: tx_req raised for a dropped request", pkt_num);
      ok = 1'b0;
    end
    if (ok)
    begin
      $display("packet %0d, %0d bytes: ok", pkt_num, req_len);
      pass_count++;
    end
    else
    begin
      $display("packet %0d, %0d bytes: failed", pkt_num, req_len);
      fail_count++;
    end
    pkt_num++;
    tx_idx    = 0;
    byte_errs = 0;
    req_seen  = 1'b0;
  endtask

  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      req_len    = 0;
      rx_idx     = 0;
      rx_left    = 0;
      tx_idx     = 0;
      byte_errs  = 0;
      pkt_num    = 1;
      pass_count = 0;
      fail_count = 0;
      req_seen   = 1'b0;
    end
    else
    begin
      if (rx_left > 0)
      begin
        if (rx_idx < 512)
          req[rx_idx] = rx_data;
        rx_idx++;
        rx_left--;
        if (rx_left == 0)
          build_expected();
      end
      else if (rx_start)
      begin
        req_len = int'(rx_len);
        rx_left = req_len;
        rx_idx  = 0;
      end
      if (tx_req)
        req_seen = 1'b1;
      if (tx_valid)
      begin
        if (tx_idx < req_len && tx_data !== expect_b[tx_idx])
        begin
          $display("Fail %0t tx_data byte %0d: got %02h, expected %02h",
                   $time, tx_idx, tx_data, expect_b[tx_idx]);
          byte_errs++;
        end
        tx_idx++;
      end
      if (pkt_done)
        close_packet();
      if (report)
        $display("checker: %0d packets, %0d passed, %0d failed",
                 pass_count + fail_count, pass_count, fail_count);
    end
  end

endmodule

/* verif/tb_icmp_reply.sv */
// ----------------------------
// testbench for the ICMP echo responder: reads packet records,
// drives the receive side and plays the IP/MAC handshake
// ----------------------------
`timescale 1ns/10ps
`include "icmp_settings.svh"

module tb_icmp_reply;

  logic            clk;
  logic            rst_n;
  logic            rx_start;
  icmp_pkg::len_t  rx_len;
  icmp_pkg::byte_t rx_data;
  logic            rx_error;
  logic            tx_ack;
  logic            tx_data_req;
  logic            mac_done;
  logic            tx_req;
  logic            tx_ready;
  logic            tx_valid;
  icmp_pkg::byte_t tx_data;
  logic            pkt_done;      // tells the checker a test is over
  logic            exp_reply;
  logic            req_allowed;
  logic            report;
  int              fail_count;
  logic            alive;         // cleared when a wait runs out
  logic [15:0]     stim [0:255];
  icmp_pkg::byte_t pkt [0:511];
  logic [31:0]     seed = 32'd2409;

  always #5 clk = ~clk;

  icmp_reply u_icmp_reply
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .rx_start    (rx_start),
    .rx_len      (rx_len),
    .rx_data     (rx_data),
    .rx_error    (rx_error),
    .tx_ack      (tx_ack),
    .tx_data_req (tx_data_req),
    .mac_done    (mac_done),
    .tx_req      (tx_req),
    .tx_ready    (tx_ready),
    .tx_valid    (tx_valid),
    .tx_data     (tx_data)
  );

  icmp_checker u_checker
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .rx_start    (rx_start),
    .rx_len      (rx_len),
    .rx_data     (rx_data),
    .tx_req      (tx_req),
    .tx_valid    (tx_valid),
    .tx_data     (tx_data),
    .pkt_done    (pkt_done),
    .exp_reply   (exp_reply),
    .req_allowed (req_allowed),
    .report      (report),
    .fail_count  (fail_count)
  );

  function automatic icmp_pkg::byte_t next_random();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[23:16];
  endfunction

  // request checksum, bytes 2 and 3 are still zero here
  function automatic icmp_pkg::word_t request_checksum(input int len);
    logic [31:0] sum;
    int          i;
    sum = '0;
    for (i = 0; i < len; i = i + 2)
      sum = sum + {16'h0, pkt[i], ((i + 1 < len) ? pkt[i+1] : 8'h00)};
    while (sum[31:16] != 16'h0)
      sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
    return ~sum[15:0];
  endfunction

  task automatic to_drive_point();
    @(posedge clk);
    #1;
  endtask

  task automatic random_pause();
    repeat (1 + int'(next_random() % 8'd5)) to_drive_point();
  endtask

  function automatic logic watched(input string name);
    if (name == "tx_req")
      return tx_req;
    else if (name == "tx_ready")
      return tx_ready;
    return tx_valid;
  endfunction

  // sampled at the falling edge, well clear of the DUT updates
  task automatic wait_for(input string name, input logic level, input int limit);
    int n;
    n = 0;
    if (!alive)
      return;
    @(negedge clk);
    while (watched(name) !== level && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (watched(name) !== level)
    begin
      $display("timeout: %s did not go to %0b within %0d cycles", name, level, limit);
      alive = 1'b0;
    end
  endtask

  task automatic send_packet(input int len, input logic err);
    int i;
    to_drive_point();
    rx_start = 1'b1;
    rx_len   = icmp_pkg::len_t'(len);
    to_drive_point();
    rx_start = 1'b0;
    for (i = 0; i < len; i++)
    begin
      rx_data  = pkt[i];
      rx_error = err && (i == len / 2);   // one pulse mid packet
      to_drive_point();
    end
    rx_data  = '0;
    rx_error = 1'b0;
  endtask

  task automatic answer_handshake(input logic hold_req);
    wait_for("tx_req", 1'b1, 20);
    random_pause();
    tx_ack = 1'b1;
    to_drive_point();
    tx_ack = 1'b0;
    wait_for("tx_ready", 1'b1, 20);
    if (hold_req)
      wait_for("tx_ready", 1'b0, `ICMP_TIMEOUT + 20);   // framer gives up
    else
    begin
      random_pause();
      tx_data_req = 1'b1;
      to_drive_point();
      tx_data_req = 1'b0;
      wait_for("tx_valid", 1'b1, 20);
      wait_for("tx_valid", 1'b0, 300);
      random_pause();
      mac_done = 1'b1;
      to_drive_point();
      mac_done = 1'b0;
    end
  endtask

  initial
  begin
    int              ptr;
    int              len;
    int              i;
    int              n_pkts;
    logic [15:0]     flags;
    icmp_pkg::word_t cks;
    clk         = 1'b0;
    rst_n       = 1'b0;
    rx_start    = 1'b0;
    rx_len      = '0;
    rx_data     = '0;
    rx_error    = 1'b0;
    tx_ack      = 1'b0;
    tx_data_req = 1'b0;
    mac_done    = 1'b0;
    pkt_done    = 1'b0;
    exp_reply   = 1'b0;
    req_allowed = 1'b0;
    report      = 1'b0;
    alive       = 1'b1;
    ptr         = 0;
    n_pkts      = 0;
    $readmemh("verif/icmp_input.txt", stim);
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (2) to_drive_point();
    while (alive && ptr < 250 && stim[ptr] != 16'h0000)
    begin
      len    = int'(stim[ptr]);
      flags  = stim[ptr+1];
      pkt[0] = stim[ptr+2][7:0];
      pkt[1] = stim[ptr+3][7:0];
      pkt[2] = 8'h00;
      pkt[3] = 8'h00;
      pkt[4] = stim[ptr+4][15:8];
      pkt[5] = stim[ptr+4][7:0];
      pkt[6] = stim[ptr+5][15:8];
      pkt[7] = stim[ptr+5][7:0];
      ptr    = ptr + 6;
      for (i = 8; i < len; i++)
        if (flags[2])
          pkt[i] = next_random();
        else
        begin
          pkt[i] = stim[ptr][7:0];
          ptr++;
        end
      cks = request_checksum(len);
      if (flags[1])
        cks = cks ^ 16'h0010;   // one flipped bit
      pkt[2] = cks[15:8];
      pkt[3] = cks[7:0];
      send_packet(len, flags[0]);
      if (flags[3] || flags[4])
        answer_handshake(flags[4]);
      else
        repeat (12) to_drive_point();   // verify takes 4 cycles, tx_req 1 more
      if (alive)
      begin
        exp_reply   = flags[3];
        req_allowed = flags[4];
        pkt_done    = 1'b1;
        to_drive_point();
        pkt_done    = 1'b0;
      end
      n_pkts++;
      repeat (2) to_drive_point();
    end
    to_drive_point();
    report = 1'b1;
    to_drive_point();
    report = 1'b0;
    @(negedge clk);
    if (alive && fail_count == 0 && n_pkts > 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* verif/icmp_input.txt */
// record: length, flags, type, code, identifier, sequence, then payload bytes
// flags: 1 rx_error, 2 bad checksum, 4 random payload, 8 reply expected, 10 hold tx_data_req
// even length echo request
0010 0008 0008 0000 1234 0001
00 11 22 33 44 55 66 77
// odd length, padded in both checksums
000D 0008 0008 0000 BEEF 0002
A1 B2 C3 D4 E5
// corrupted checksum
000C 0002 0008 0000 0042 0003
DE AD BE EF
// timestamp request, wrong type
000C 0000 000D 0000 0042 0004
01 02 03 04
// answered after the drops, nonzero code
000A 0008 0008 0005 0777 0005
5A A5
// rx_error pulse
0010 0001 0008 0000 0100 0006
10 32 54 76 98 BA DC FE
// full size, random payload
0108 000C 0008 0000 ABCD 0007
// tx_data_req held off past the timeout
000C 0010 0008 0000 0101 0008
10 20 30 40
// answered after the timeout
000B 0008 0008 0000 0102 0009
0A 0B 0C
// too short
0006 0000 0008 0000 0000 000A
// too long, random payload
012C 0004 0008 0000 0000 000B
// end of records
0000

/* vlog.f */
+incdir+design
design/icmp_pkg.sv
design/icmp_payload_ram.sv
design/icmp_rx_parser.sv
design/icmp_tx_framer.sv
design/icmp_reply.sv
verif/icmp_checker.sv
verif/tb_icmp_reply.sv

/* Makefile */
TOP = tb_icmp_reply

.PHONY: help test clean

help:
	@echo "make test   compile with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
